//--- hw/led_pkg.sv
// --------------------------------------------------------------------------
// LED color engine package
// Widths, Wishbone register map, mode and phase enums, shared structs
// --------------------------------------------------------------------------

package led_pkg;

  // Datapath widths
  localparam int DUTY_W   = 8;   // One color duty, also the PWM counter
  localparam int POS_W    = 10;  // Phase (2) plus ramp (8)
  localparam int RATE_W   = 8;   // Step prescaler divider
  localparam int WB_ADR_W = 2;   // Word address
  localparam int WB_DAT_W = 32;

  // Register map, word addresses
  localparam logic [WB_ADR_W-1:0] ADR_CTRL   = 2'd0;
  localparam logic [WB_ADR_W-1:0] ADR_COLOR  = 2'd1;
  localparam logic [WB_ADR_W-1:0] ADR_STATUS = 2'd2;  // Read only

  // Value 3 is legal in the register and behaves as off
  typedef enum logic [1:0] {
    MODE_OFF    = 2'd0,
    MODE_MANUAL = 2'd1,
    MODE_CYCLE  = 2'd2
  } led_mode_e;

  // Four quarters of the hue wheel
  typedef enum logic [1:0] {
    PH_RED_UP     = 2'd0,
    PH_GREEN_UP   = 2'd1,
    PH_RED_DOWN   = 2'd2,
    PH_GREEN_DOWN = 2'd3
  } hue_phase_e;

  typedef struct packed {
    logic [DUTY_W-1:0] r;
    logic [DUTY_W-1:0] g;
    logic [DUTY_W-1:0] b;
  } rgb_duty_t;

  // Master side of Wishbone classic
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;
  } wb_req_t;

  // Slave side
  typedef struct packed {
    logic                ack;
    logic [WB_DAT_W-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    led_mode_e         mode;
    logic [RATE_W-1:0] rate_div;  // Periods per step, minus one
    rgb_duty_t         manual;
  } led_ctrl_t;

  typedef struct packed {
    hue_phase_e        phase;
    logic [DUTY_W-1:0] ramp;
  } seq_status_t;

endpackage

//--- hw/led_wb_regs.sv
// --------------------------------------------------------------------------
// LED register block
// Wishbone classic slave holding CTRL and COLOR, with live STATUS readback
// Single-cycle ack, no wait states
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module led_wb_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  led_pkg::wb_req_t     wb_req,
  output led_pkg::wb_rsp_t     wb_rsp,
  output led_pkg::led_ctrl_t   ctrl,
  input  led_pkg::seq_status_t status
);

  import led_pkg::*;

  logic                req;      // Accepted transfer this cycle
  logic                ack_q;
  logic [WB_DAT_W-1:0] rdata_d;  // Read mux output
  logic [WB_DAT_W-1:0] rdata_q;

  // Request seen and no ack last cycle
  // Keeps ack to one cycle even if stb lingers
  assign req = wb_req.cyc & wb_req.stb & ~ack_q;

  // Read mux, undefined bits stay zero
  always_comb begin
    rdata_d = '0;
    case (wb_req.adr)
      ADR_CTRL: begin
        rdata_d[1:0]  = ctrl.mode;      // Raw 2 bits, 3 reads back as 3
        rdata_d[15:8] = ctrl.rate_div;
      end
      ADR_COLOR: begin
        rdata_d[7:0]   = ctrl.manual.r;
        rdata_d[15:8]  = ctrl.manual.g;
        rdata_d[23:16] = ctrl.manual.b;
      end
      ADR_STATUS: begin
        rdata_d[7:0] = status.ramp;     // Sampled live
        rdata_d[9:8] = status.phase;
      end
      default: ;                        // Address 3 reads zero
    endcase
  end

  // Control registers and ack
  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl  <= '0;        // Off, no divide, black
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
      if (req && wb_req.we) begin
        // Whole-register writes, no byte selects
        case (wb_req.adr)
          ADR_CTRL: begin
            ctrl.mode     <= led_mode_e'(wb_req.dat[1:0]);
            ctrl.rate_div <= wb_req.dat[15:8];
          end
          ADR_COLOR: begin
            ctrl.manual.r <= wb_req.dat[7:0];
            ctrl.manual.g <= wb_req.dat[15:8];
            ctrl.manual.b <= wb_req.dat[23:16];
          end
          default: ;      // STATUS and address 3 ignore writes
        endcase
      end
    end
  end

  // Read data captured with the ack edge
  always_ff @(posedge clk) begin
    if (req && !wb_req.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rdata_q;  // Valid while ack is high

endmodule

//--- hw/color_sequencer.sv
// --------------------------------------------------------------------------
// Color sequencer
// Steps a phase/ramp position once every rate_div+1 PWM periods and maps it
// onto the hue wheel, or passes the manual color through
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module color_sequencer (
  input  logic                 clk,
  input  logic                 reset,
  input  led_pkg::led_ctrl_t   ctrl,
  input  logic                 period_end,
  output led_pkg::seq_status_t status,
  output led_pkg::rgb_duty_t   duty
);

  import led_pkg::*;

  logic              cycle_on;  // Sequencer running
  logic              step;      // Advance position this cycle
  logic [RATE_W-1:0] presc_q;   // Counts period_end pulses
  logic [POS_W-1:0]  pos_q;     // {phase, ramp}
  hue_phase_e        phase;
  logic [DUTY_W-1:0] ramp;
  rgb_duty_t         hue;       // Table output

  assign cycle_on = (ctrl.mode == MODE_CYCLE);

  // >= so a lowered divider never strands the prescaler
  assign step = period_end && (presc_q >= ctrl.rate_div);

  // Prescaler and position, both held clear outside cycle mode
  always_ff @(posedge clk) begin
    if (reset || !cycle_on) begin
      presc_q <= '0;
      pos_q   <= '0;
    end else if (period_end) begin
      if (step) begin
        presc_q <= '0;
        pos_q   <= pos_q + 1'b1;  // Wraps after four phases
      end else begin
        presc_q <= presc_q + 1'b1;
      end
    end
  end

  assign phase = hue_phase_e'(pos_q[POS_W-1:DUTY_W]);
  assign ramp  = pos_q[DUTY_W-1:0];

  // Hue wheel, ~ramp is 255 minus ramp
  always_comb begin
    case (phase)
      PH_RED_UP: begin      // Blue fades into red
        hue.r = ramp;
        hue.g = '0;
        hue.b = ~ramp;
      end
      PH_GREEN_UP: begin    // Red to yellow
        hue.r = '1;
        hue.g = ramp;
        hue.b = '0;
      end
      PH_RED_DOWN: begin    // Yellow to green
        hue.r = ~ramp;
        hue.g = '1;
        hue.b = '0;
      end
      default: begin        // PH_GREEN_DOWN, green to blue
        hue.r = '0;
        hue.g = ~ramp;
        hue.b = ramp;
      end
    endcase
  end

  // Mode select
  always_comb begin
    case (ctrl.mode)
      MODE_MANUAL: duty = ctrl.manual;
      MODE_CYCLE:  duty = hue;
      default:     duty = '0;  // Off, and the unnamed value 3
    endcase
  end

  assign status.phase = phase;
  assign status.ramp  = ramp;

endmodule

//--- hw/pwm_bank.sv
// --------------------------------------------------------------------------
// PWM bank
// Shared 8-bit counter with three registered comparators
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module pwm_bank (
  input  logic               clk,
  input  logic               reset,
  input  led_pkg::rgb_duty_t duty,
  output logic               period_end,
  output logic               led_r,
  output logic               led_g,
  output logic               led_b
);

  import led_pkg::*;

  logic [DUTY_W-1:0] cnt_q;   // Free running, 256 states
  rgb_duty_t         duty_q;  // Duty for the current period

  assign period_end = (cnt_q == '1);  // Last state, 255

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q  <= '0;
      duty_q <= '0;
      led_r  <= 1'b0;
      led_g  <= 1'b0;
      led_b  <= 1'b0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
      // Latch only on the wrap so a pulse is never cut short
      if (period_end) begin
        duty_q <= duty;
      end
      // High for exactly duty counts of every 256
      led_r <= (cnt_q < duty_q.r);
      led_g <= (cnt_q < duty_q.g);
      led_b <= (cnt_q < duty_q.b);
    end
  end

endmodule

//--- hw/led_pwm_top.sv
// --------------------------------------------------------------------------
// RGB LED color engine top
// Wishbone register block, color sequencer and PWM bank
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module led_pwm_top (
  input  logic             clk,
  input  logic             reset,
  input  led_pkg::wb_req_t wb_req,
  output led_pkg::wb_rsp_t wb_rsp,
  output logic             led_r,   // To the LED current driver
  output logic             led_g,
  output logic             led_b
);

  import led_pkg::*;

  led_ctrl_t   ctrl;        // Registered mode, divider, manual color
  seq_status_t status;      // Live position for STATUS reads
  rgb_duty_t   duty;        // Requested duty, combinational
  logic        period_end;  // PWM wrap strobe

  led_wb_regs led_wb_regs_inst (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .ctrl   (ctrl),
    .status (status)
  );

  color_sequencer color_sequencer_inst (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl),
    .period_end (period_end),
    .status     (status),
    .duty       (duty)
  );

  pwm_bank pwm_bank_inst (
    .clk        (clk),
    .reset      (reset),
    .duty       (duty),
    .period_end (period_end),
    .led_r      (led_r),
    .led_g      (led_g),
    .led_b      (led_b)
  );

endmodule

//--- verif/led_pwm_assert.sv
// --------------------------------------------------------------------------
// LED engine checker
// Wishbone ack protocol, reset state and off-mode output rules, bound to
// the top level
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module led_pwm_assert (
  input logic                 clk,
  input logic                 reset,
  input led_pkg::wb_req_t     wb_req,
  input led_pkg::wb_rsp_t     wb_rsp,
  input led_pkg::led_ctrl_t   ctrl,
  input logic                 led_r,
  input logic                 led_g,
  input logic                 led_b
);

  import led_pkg::*;

  localparam int OFF_SETTLE = 2 * (1 << DUTY_W);  // Two PWM periods

  int   fail_cnt = 0;    // Failed assertions so far
  int   off_cycles;      // Cycles spent in an off mode, saturating
  logic off_mode;
  logic reset_q = 1'b0;  // Reset one cycle ago

  assign off_mode = (ctrl.mode != MODE_MANUAL) && (ctrl.mode != MODE_CYCLE);  // 0 and 3

  always_ff @(posedge clk) begin
    reset_q <= reset;
    if (reset || !off_mode) begin
      off_cycles <= 0;
    end else if (off_cycles < OFF_SETTLE) begin
      off_cycles <= off_cycles + 1;
    end
  end

  // Ack only answers a request from the previous cycle
  ack_after_req: assert property (@(posedge clk) disable iff (reset)
    wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
    else begin
      fail_cnt++;
      $error("ack raised without cyc and stb in the previous cycle");
    end

  ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_rsp.ack |=> !wb_rsp.ack)  // Never two in a row
    else begin
      fail_cnt++;
      $error("ack high on two consecutive cycles");
    end

  reset_quiet: assert property (@(posedge clk)
    reset_q |-> (!wb_rsp.ack && !led_r && !led_g && !led_b))
    else begin
      fail_cnt++;
      $error("ack or LED output high in the cycle after reset");
    end

  // New duty reaches the pins within two periods
  off_dark: assert property (@(posedge clk) disable iff (reset)
    (off_cycles == OFF_SETTLE) |-> (!led_r && !led_g && !led_b))
    else begin
      fail_cnt++;
      $error("LED output high while mode is off");
    end

endmodule

bind led_pwm_top led_pwm_assert led_pwm_assert_inst (
  .clk    (clk),
  .reset  (reset),
  .wb_req (wb_req),
  .wb_rsp (wb_rsp),
  .ctrl   (ctrl),
  .led_r  (led_r),
  .led_g  (led_g),
  .led_b  (led_b)
);

//--- verif/led_pwm_tb.sv
// --------------------------------------------------------------------------
// LED color engine testbench
// Wishbone register access, off, manual and hue-cycle modes checked by
// measuring PWM high counts over full periods
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module led_pwm_tb;

  import led_pkg::*;

  localparam int    CLK_NS    = 10;
  localparam int    PERIOD    = 256;  // PWM period in cycles
  localparam int    TOTAL_CYC = 2000 + 3000 + 4000 + 85000;  // Regs, off, manual, cycle
  localparam longint WDOG_NS  = 64'd40 * TOTAL_CYC * CLK_NS;

  logic    clk;
  logic    reset;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic    led_r;
  logic    led_g;
  logic    led_b;
  integer  seed;
  int      hue_points = 0;  // Stable STATUS points checked against the table

  led_pwm_top led_pwm_top_inst (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .led_r  (led_r),
    .led_g  (led_g),
    .led_b  (led_b)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("ERROR @ %0t: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // One classic cycle, request on a rising edge, ack seen at the falling edge
  task automatic wb_xfer(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                         output logic [31:0] rdat);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    @(negedge clk);
    while (!wb_rsp.ack) begin
      waited++;
      assert (waited < 8) else stop_on_error("Wishbone ack did not arrive within 8 cycles");
      @(negedge clk);
    end
    rdat = wb_rsp.dat;
    @(posedge clk);
    wb_req <= '0;  // Drop stb after ack
  endtask

  function automatic logic [31:0] ctrl_word(input led_mode_e mode, input logic [7:0] rate);
    return {16'd0, rate, 6'd0, mode};
  endfunction

  // Hue wheel from the color rule, down is 255 minus ramp
  function automatic rgb_duty_t hue_ref(input hue_phase_e phase, input logic [7:0] ramp);
    logic [7:0] down;
    down = 8'd255 - ramp;
    case (phase)
      PH_RED_UP:   return '{r: ramp, g: 8'd0, b: down};
      PH_GREEN_UP: return '{r: 8'd255, g: ramp, b: 8'd0};
      PH_RED_DOWN: return '{r: down, g: 8'd255, b: 8'd0};
      default:     return '{r: 8'd0, g: down, b: ramp};
    endcase
  endfunction

  // High cycles per LED over one full window
  task automatic measure(output int hr, output int hg, output int hb);
    hr = 0;
    hg = 0;
    hb = 0;
    repeat (PERIOD) begin
      @(negedge clk);
      hr += led_r;
      hg += led_g;
      hb += led_b;
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp)
      else stop_on_error($sformatf("%s read 0x%h, expected 0x%h", what, got, exp));
  endtask

  task automatic check_counts(input int hr, input int hg, input int hb, input rgb_duty_t exp,
                              input string what);
    assert (hr == exp.r && hg == exp.g && hb == exp.b)
      else stop_on_error($sformatf("%s: high counts r=%0d g=%0d b=%0d, expected %0d %0d %0d",
                                   what, hr, hg, hb, exp.r, exp.g, exp.b));
  endtask

  task automatic test_registers();
    logic [31:0] ctrl_w;
    logic [31:0] color_w;
    logic [31:0] rd;
    for (int i = 0; i < 8; i++) begin
      ctrl_w  = $random(seed);
      color_w = $random(seed);
      if (i == 0) begin
        ctrl_w[1:0] = 2'd3;  // Unnamed mode value
      end
      wb_xfer(1'b1, ADR_CTRL, ctrl_w, rd);
      wb_xfer(1'b1, ADR_COLOR, color_w, rd);
      wb_xfer(1'b0, ADR_CTRL, '0, rd);
      check_word(rd, ctrl_w & 32'h0000_ff03, "CTRL");
      wb_xfer(1'b0, ADR_COLOR, '0, rd);
      check_word(rd, color_w & 32'h00ff_ffff, "COLOR");
    end
    wb_xfer(1'b1, 2'd3, 32'hffff_ffff, rd);  // Unmapped word
    wb_xfer(1'b0, 2'd3, '0, rd);
    check_word(rd, '0, "address 3");
  endtask

  task automatic test_off();
    logic [31:0] rd;
    int hr;
    int hg;
    int hb;
    wb_xfer(1'b1, ADR_COLOR, 32'h00ff_ffff, rd);  // Full white
    for (int i = 0; i < 2; i++) begin
      wb_xfer(1'b1, ADR_CTRL, ctrl_word(MODE_MANUAL, 8'd0), rd);
      repeat (2 * PERIOD) @(posedge clk);  // LEDs lit before switching off
      wb_xfer(1'b1, ADR_CTRL, (i == 0) ? ctrl_word(MODE_OFF, 8'd7) : 32'h3, rd);
      repeat (2 * PERIOD) @(posedge clk);
      measure(hr, hg, hb);
      check_counts(hr, hg, hb, '0, "off mode");
    end
  endtask

  task automatic test_manual();
    logic [31:0] rd;
    logic [23:0] color;
    int hr;
    int hg;
    int hb;
    wb_xfer(1'b1, ADR_CTRL, ctrl_word(MODE_MANUAL, 8'd0), rd);
    for (int i = 0; i < 4; i++) begin
      case (i)
        0:       color = 24'h00_0000;
        1:       color = 24'hff_ffff;
        default: color = $random(seed);
      endcase
      wb_xfer(1'b1, ADR_COLOR, {8'd0, color}, rd);
      repeat (2 * PERIOD) @(posedge clk);  // Latch plus output register
      measure(hr, hg, hb);
      check_counts(hr, hg, hb, '{r: color[7:0], g: color[15:8], b: color[23:16]}, "manual");
    end
  endtask

  // STATUS before and after, so a step during the window skips the point
  task automatic check_hue_point();
    logic [31:0] st_a;
    logic [31:0] st_b;
    int hr;
    int hg;
    int hb;
    wb_xfer(1'b0, ADR_STATUS, '0, st_a);
    repeat (2 * PERIOD) @(posedge clk);
    measure(hr, hg, hb);
    wb_xfer(1'b0, ADR_STATUS, '0, st_b);
    if (st_a == st_b) begin
      hue_points++;
      check_counts(hr, hg, hb, hue_ref(hue_phase_e'(st_a[9:8]), st_a[7:0]), "hue table");
    end
  endtask

  task automatic check_steps(input int n, output logic [31:0] st0, output logic [31:0] st1);
    int moved;
    wb_xfer(1'b0, ADR_STATUS, '0, st0);
    repeat (n * PERIOD) @(posedge clk);  // One step per period at divider 0
    wb_xfer(1'b0, ADR_STATUS, '0, st1);
    moved = (st1[9:0] - st0[9:0]) & 10'h3ff;
    assert (moved >= n - 1 && moved <= n + 1)
      else stop_on_error($sformatf("position moved %0d steps over %0d periods", moved, n));
  endtask

  task automatic test_cycle();
    logic [31:0] st0;
    logic [31:0] st1;
    logic [31:0] rd;
    wb_xfer(1'b1, ADR_CTRL, ctrl_word(MODE_OFF, 8'd0), rd);  // Clears position
    wb_xfer(1'b1, ADR_CTRL, ctrl_word(MODE_CYCLE, 8'd0), rd);
    check_steps(100, st0, st1);
    wb_xfer(1'b1, ADR_CTRL, ctrl_word(MODE_CYCLE, 8'd255), rd);  // Near frozen
    check_hue_point();
    check_hue_point();
    wb_xfer(1'b1, ADR_CTRL, ctrl_word(MODE_CYCLE, 8'd0), rd);
    check_steps(200, st0, st1);  // Crosses ramp 255 into the next phase
    check_word(st0[9:8], PH_RED_UP, "phase before wrap");
    check_word(st1[9:8], PH_GREEN_UP, "phase after wrap");
    wb_xfer(1'b1, ADR_CTRL, ctrl_word(MODE_CYCLE, 8'd255), rd);
    check_hue_point();
    check_hue_point();
    wb_xfer(1'b1, ADR_CTRL, ctrl_word(MODE_MANUAL, 8'd0), rd);
    wb_xfer(1'b0, ADR_STATUS, '0, rd);
    check_word(rd, '0, "STATUS outside cycle mode");
    wb_xfer(1'b1, ADR_CTRL, ctrl_word(MODE_CYCLE, 8'd255), rd);
    wb_xfer(1'b0, ADR_STATUS, '0, rd);
    check_word(rd, '0, "STATUS after re-entering cycle mode");
  endtask

  // Bound checker counts its own failures
  always @(negedge clk) begin
    if (led_pwm_top_inst.led_pwm_assert_inst.fail_cnt != 0) begin
      stop_on_error("a bound protocol or output assertion failed");
    end
  end

  initial begin
    #(WDOG_NS);
    stop_on_error("watchdog expired before the tests finished");
  end

  initial begin
    reset  <= 1'b1;
    wb_req <= '0;
    seed = 78;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    test_registers();
    test_off();
    test_manual();
    test_cycle();
    if (hue_points >= 3) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      stop_on_error("too few stable STATUS points for the hue table check");
    end
  end

endmodule

//--- led_pwm_top.f
hw/led_pkg.sv
hw/led_wb_regs.sv
hw/color_sequencer.sv
hw/pwm_bank.sv
hw/led_pwm_top.sv
verif/led_pwm_assert.sv
verif/led_pwm_tb.sv

//--- Bender.yml
package:
  name: led_pwm

sources:
  - files:
      - hw/led_pkg.sv
      - hw/led_wb_regs.sv
      - hw/color_sequencer.sv
      - hw/pwm_bank.sv
      - hw/led_pwm_top.sv
  - target: test
    files:
      - verif/led_pwm_assert.sv
      - verif/led_pwm_tb.sv
